//--- src/rd_engine_pkg.sv
// Read burst engine shared definitions
// Widths, channel count and the AXI burst, response and arbiter enums

package rd_engine_pkg;

    // ========================================
    // Channel and bus sizes
    // ========================================
    localparam int NUM_CH  = 4;
    // Channel index width
    localparam int CH_W    = 2;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    // Channel index sits in the low ID bits
    localparam int ID_W    = 4;
    // Remaining beats from the scheduler
    localparam int BEATS_W = 16;
    // Burst length, config beats and alloc size
    localparam int LEN_W   = 8;
    localparam int SPACE_W = 8;
    // log2 of bytes per 32-bit beat
    localparam int AXSIZE_VAL = 2;

    // ========================================
    // AXI encodings
    // ========================================
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Arbiter FSM
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_HOLD = 1'b1
    } arb_state_e;

endpackage

//--- src/rd_channel_gate.sv
// Per-channel request gate
// Sizes the next burst, checks SRAM space and tracks the one outstanding burst

`timescale 1ns/1ps

module rd_channel_gate (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sched_valid,
    input  logic [rd_engine_pkg::BEATS_W-1:0] sched_beats,
    input  logic [rd_engine_pkg::LEN_W-1:0]   cfg_xfer_beats,
    input  logic [rd_engine_pkg::SPACE_W-1:0] space_free,
    input  logic                              ack,
    input  logic                              burst_end,
    output logic                              request,
    output logic [rd_engine_pkg::LEN_W-1:0]   arlen
);

    // Configured burst as a beat count
    logic [rd_engine_pkg::BEATS_W-1:0] cfg_beats;
    // Remaining beats in burst-length form
    logic [rd_engine_pkg::BEATS_W-1:0] last_beat;
    // Beats the SRAM must hold, one bit wider than arlen
    logic [rd_engine_pkg::LEN_W:0]     need;
    logic                              space_ok;
    logic                              outstanding;

    // ========================================
    // Transfer size
    // ========================================
    assign cfg_beats = {{(rd_engine_pkg::BEATS_W - rd_engine_pkg::LEN_W){1'b0}},
                        cfg_xfer_beats} + 1'b1;
    assign last_beat = sched_beats - 1'b1;

    // Short tail goes out whole, else a full configured burst
    assign arlen = (sched_beats <= cfg_beats) ?
                   last_beat[rd_engine_pkg::LEN_W-1:0] : cfg_xfer_beats;

    // Space check against the whole burst
    assign need     = {1'b0, arlen} + 1'b1;
    assign space_ok = ({1'b0, space_free} >= need);

    // ========================================
    // Outstanding burst flag
    // ========================================
    // Set on AR acceptance, cleared once rlast for this channel is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (ack) begin
            outstanding <= 1'b1;
        end else if (burst_end) begin
            outstanding <= 1'b0;
        end
    end

    // Only compete when all three conditions hold
    assign request = sched_valid && space_ok && !outstanding;

endmodule

//--- src/rr_arbiter.sv
// Round-robin arbiter
// Registers one grant and holds it until the AR transfer acknowledges it

`timescale 1ns/1ps

module rr_arbiter (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [rd_engine_pkg::NUM_CH-1:0] request,
    input  logic [rd_engine_pkg::NUM_CH-1:0] ack,
    output logic                             grant_valid,
    output logic [rd_engine_pkg::NUM_CH-1:0] grant,
    output logic [rd_engine_pkg::CH_W-1:0]   grant_idx
);

    rd_engine_pkg::arb_state_e state;
    // Highest-priority channel for the next pick
    logic [rd_engine_pkg::CH_W-1:0] ptr;
    logic [rd_engine_pkg::CH_W-1:0] pick_idx;
    logic                           pick_found;

    // ========================================
    // Rotating priority search
    // ========================================
    // First requester at or after the pointer, wrapping around
    always_comb begin
        logic [rd_engine_pkg::CH_W-1:0] idx;
        pick_idx   = ptr;
        pick_found = 1'b0;
        for (int i = 0; i < rd_engine_pkg::NUM_CH; i++) begin
            idx = ptr + i[rd_engine_pkg::CH_W-1:0];
            if (!pick_found && request[idx]) begin
                pick_idx   = idx;
                pick_found = 1'b1;
            end
        end
    end

    // ========================================
    // Grant FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rd_engine_pkg::ARB_IDLE;
            ptr       <= '0;
            grant     <= '0;
            grant_idx <= '0;
        end else begin
            case (state)
                rd_engine_pkg::ARB_IDLE: begin
                    if (pick_found) begin
                        // Registered grant, AR goes valid next cycle
                        grant           <= '0;
                        grant[pick_idx] <= 1'b1;
                        grant_idx       <= pick_idx;
                        state           <= rd_engine_pkg::ARB_HOLD;
                    end
                end
                rd_engine_pkg::ARB_HOLD: begin
                    // Hold through AR back-pressure
                    if (|(ack & grant)) begin
                        grant <= '0;
                        // Channel after the winner gets top priority
                        ptr   <= grant_idx + 1'b1;
                        state <= rd_engine_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= rd_engine_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    assign grant_valid = (state == rd_engine_pkg::ARB_HOLD);

endmodule

//--- src/ar_issue.sv
// AR command issue
// Muxes the granted channel onto AR, acknowledges the grant, and pulses
// the SRAM allocation and the scheduler done strobe after each transfer

`timescale 1ns/1ps

module ar_issue (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic                                                     grant_valid,
    input  logic [rd_engine_pkg::NUM_CH-1:0]                         grant,
    input  logic [rd_engine_pkg::CH_W-1:0]                           grant_idx,
    input  logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::ADDR_W-1:0] sched_addr,
    input  logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::LEN_W-1:0]  chan_arlen,
    input  logic                                                     arready,
    output logic [rd_engine_pkg::NUM_CH-1:0]                         ack,
    output logic                                                     arvalid,
    output logic [rd_engine_pkg::ID_W-1:0]                           arid,
    output logic [rd_engine_pkg::ADDR_W-1:0]                         araddr,
    output logic [rd_engine_pkg::LEN_W-1:0]                          arlen,
    output logic [2:0]                                               arsize,
    output rd_engine_pkg::burst_e                                    arburst,
    output logic                                                     alloc_req,
    output logic [rd_engine_pkg::LEN_W-1:0]                          alloc_size,
    output logic [rd_engine_pkg::ID_W-1:0]                           alloc_id,
    output logic [rd_engine_pkg::NUM_CH-1:0]                         sched_done,
    output logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::BEATS_W-1:0] sched_beats_done
);

    logic                              ar_xfer;
    // Burst beat count in allocation and scheduler widths
    logic [rd_engine_pkg::LEN_W-1:0]   alloc_beats;
    logic [rd_engine_pkg::BEATS_W-1:0] done_beats;

    // ========================================
    // AR bus
    // ========================================
    // Grant is registered, so every field stays stable until accepted
    assign arvalid = grant_valid;
    assign arid    = {{(rd_engine_pkg::ID_W - rd_engine_pkg::CH_W){1'b0}}, grant_idx};
    assign araddr  = sched_addr[grant_idx];
    assign arlen   = chan_arlen[grant_idx];
    assign arsize  = 3'(rd_engine_pkg::AXSIZE_VAL);
    assign arburst = rd_engine_pkg::BURST_INCR;

    assign ar_xfer = arvalid && arready;

    // Back to the arbiter and the granted channel's gate
    assign ack = grant & {rd_engine_pkg::NUM_CH{ar_xfer}};

    assign alloc_beats = arlen + 1'b1;
    assign done_beats  = {{(rd_engine_pkg::BEATS_W - rd_engine_pkg::LEN_W){1'b0}}, arlen}
                         + 1'b1;

    // ========================================
    // Allocation pulse and done strobe
    // ========================================
    // One-cycle pulses in the cycle after the AR transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_req  <= 1'b0;
            sched_done <= '0;
        end else begin
            alloc_req  <= ar_xfer;
            sched_done <= ack;
        end
    end

    // Payload, beat counts hold between strobes
    always_ff @(posedge clk) begin
        if (ar_xfer) begin
            alloc_size                  <= alloc_beats;
            alloc_id                    <= arid;
            sched_beats_done[grant_idx] <= done_beats;
        end
    end

endmodule

//--- src/r_response.sv
// R channel handler
// Zero-latency pass-through to SRAM, burst-end decode and sticky errors

`timescale 1ns/1ps

module r_response (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rvalid,
    input  logic [rd_engine_pkg::ID_W-1:0]   rid,
    input  logic [rd_engine_pkg::DATA_W-1:0] rdata,
    input  rd_engine_pkg::resp_e             rresp,
    input  logic                             rlast,
    input  logic                             sram_ready,
    output logic                             rready,
    output logic                             sram_valid,
    output logic [rd_engine_pkg::ID_W-1:0]   sram_id,
    output logic [rd_engine_pkg::DATA_W-1:0] sram_data,
    output logic [rd_engine_pkg::NUM_CH-1:0] burst_end,
    output logic [rd_engine_pkg::NUM_CH-1:0] sched_error
);

    logic                           beat;
    // Channel carried in the low ID bits
    logic [rd_engine_pkg::CH_W-1:0] rch;

    // SRAM back-pressure reaches the slave directly
    assign rready     = sram_ready;
    assign sram_valid = rvalid;
    assign sram_id    = rid;
    assign sram_data  = rdata;

    assign beat = rvalid && rready;
    assign rch  = rid[rd_engine_pkg::CH_W-1:0];

    // Last accepted beat of a channel's burst
    always_comb begin
        burst_end      = '0;
        burst_end[rch] = beat && rlast;
    end

    // Sticky per channel, only reset clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sched_error <= '0;
        end else if (beat && (rresp != rd_engine_pkg::RESP_OKAY)) begin
            sched_error[rch] <= 1'b1;
        end
    end

endmodule

//--- src/rd_engine_top.sv
// Four-channel read burst engine
// Space-aware round-robin AR issue with SRAM pre-allocation and a
// straight R-to-SRAM data path

`timescale 1ns/1ps

module rd_engine_top (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    // Scheduler side
    input  logic [rd_engine_pkg::NUM_CH-1:0]                            sched_valid,
    input  logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::ADDR_W-1:0]  sched_addr,
    input  logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::BEATS_W-1:0] sched_beats,
    input  logic [rd_engine_pkg::LEN_W-1:0]                             cfg_xfer_beats,
    output logic [rd_engine_pkg::NUM_CH-1:0]                            sched_done,
    output logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::BEATS_W-1:0] sched_beats_done,
    output logic [rd_engine_pkg::NUM_CH-1:0]                            sched_error,
    // SRAM side
    output logic                                                        alloc_req,
    output logic [rd_engine_pkg::LEN_W-1:0]                             alloc_size,
    output logic [rd_engine_pkg::ID_W-1:0]                              alloc_id,
    input  logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::SPACE_W-1:0] space_free,
    output logic                                                        sram_valid,
    output logic [rd_engine_pkg::ID_W-1:0]                              sram_id,
    output logic [rd_engine_pkg::DATA_W-1:0]                            sram_data,
    input  logic                                                        sram_ready,
    // AXI AR channel
    output logic                                                        arvalid,
    input  logic                                                        arready,
    output logic [rd_engine_pkg::ID_W-1:0]                              arid,
    output logic [rd_engine_pkg::ADDR_W-1:0]                            araddr,
    output logic [rd_engine_pkg::LEN_W-1:0]                             arlen,
    output logic [2:0]                                                  arsize,
    output rd_engine_pkg::burst_e                                       arburst,
    // AXI R channel
    input  logic                                                        rvalid,
    output logic                                                        rready,
    input  logic [rd_engine_pkg::ID_W-1:0]                              rid,
    input  logic [rd_engine_pkg::DATA_W-1:0]                            rdata,
    input  rd_engine_pkg::resp_e                                        rresp,
    input  logic                                                        rlast
);

    logic [rd_engine_pkg::NUM_CH-1:0]                           arb_request;
    logic [rd_engine_pkg::NUM_CH-1:0][rd_engine_pkg::LEN_W-1:0] chan_arlen;
    logic                                                       grant_valid;
    logic [rd_engine_pkg::NUM_CH-1:0]                           grant;
    logic [rd_engine_pkg::CH_W-1:0]                             grant_idx;
    // AR acceptance per channel
    logic [rd_engine_pkg::NUM_CH-1:0]                           ack;
    // rlast accepted per channel
    logic [rd_engine_pkg::NUM_CH-1:0]                           burst_end;

    // ========================================
    // Channel gates
    // ========================================
    for (genvar ch = 0; ch < rd_engine_pkg::NUM_CH; ch++) begin : gen_gate
        rd_channel_gate u_gate (
            .clk            (clk),
            .rst_n          (rst_n),
            .sched_valid    (sched_valid[ch]),
            .sched_beats    (sched_beats[ch]),
            .cfg_xfer_beats (cfg_xfer_beats),
            .space_free     (space_free[ch]),
            .ack            (ack[ch]),
            .burst_end      (burst_end[ch]),
            .request        (arb_request[ch]),
            .arlen          (chan_arlen[ch])
        );
    end

    rr_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (arb_request),
        .ack         (ack),
        .grant_valid (grant_valid),
        .grant       (grant),
        .grant_idx   (grant_idx)
    );

    // ========================================
    // AR issue and R return
    // ========================================
    ar_issue u_ar_issue (
        .clk              (clk),
        .rst_n            (rst_n),
        .grant_valid      (grant_valid),
        .grant            (grant),
        .grant_idx        (grant_idx),
        .sched_addr       (sched_addr),
        .chan_arlen       (chan_arlen),
        .arready          (arready),
        .ack              (ack),
        .arvalid          (arvalid),
        .arid             (arid),
        .araddr           (araddr),
        .arlen            (arlen),
        .arsize           (arsize),
        .arburst          (arburst),
        .alloc_req        (alloc_req),
        .alloc_size       (alloc_size),
        .alloc_id         (alloc_id),
        .sched_done       (sched_done),
        .sched_beats_done (sched_beats_done)
    );

    r_response u_r_response (
        .clk         (clk),
        .rst_n       (rst_n),
        .rvalid      (rvalid),
        .rid         (rid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .sram_ready  (sram_ready),
        .rready      (rready),
        .sram_valid  (sram_valid),
        .sram_id     (sram_id),
        .sram_data   (sram_data),
        .burst_end   (burst_end),
        .sched_error (sched_error)
    );

endmodule

//--- verif/rd_engine_tb.sv
// Read burst engine testbench
// Acts as scheduler, AXI read slave and SRAM; replays the golden vectors

`timescale 1ns/1ps

module rd_engine_tb;

    logic clk;
    logic rst_n;
    logic [3:0] sched_valid;
    logic [3:0][31:0] sched_addr;
    logic [3:0][15:0] sched_beats;
    logic [7:0] cfg_xfer_beats;
    logic [3:0] sched_done;
    logic [3:0][15:0] sched_beats_done;
    logic [3:0] sched_error;
    logic alloc_req;
    logic [7:0] alloc_size;
    logic [3:0] alloc_id;
    logic [3:0][7:0] space_free;
    logic sram_valid;
    logic [3:0] sram_id;
    logic [31:0] sram_data;
    logic sram_ready;
    logic arvalid;
    logic arready;
    logic [3:0] arid;
    logic [31:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    rd_engine_pkg::burst_e arburst;
    logic rvalid;
    logic rready;
    logic [3:0] rid;
    logic [31:0] rdata;
    rd_engine_pkg::resp_e rresp;
    logic rlast;

    int errors = 0;
    int tests = 0;
    int failed = 0;
    // arready level after each AR transfer
    logic ready_hold = 1'b0;
    logic [31:0] lcg_state = 32'd10;
    // Sticky error flags the engine should show
    logic [3:0] exp_err = '0;

    rd_engine_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input int start);
        tests++;
        if (errors != start) failed++;
        $display("test %0d %s", num, (errors == start) ? "ok" : "mismatch");
    endtask

    // ========================================
    // AR slave side and allocation check
    // ========================================
    // Called at a falling edge; accepts one command and checks the pulses after it
    task automatic issue_check(input int ch, input logic [31:0] addr,
                               input logic [7:0] len, input logic [7:0] size);
        int t;
        t = 0;
        while (!arvalid && t < 100) begin
            @(negedge clk);
            t++;
        end
        assert (arvalid) else begin
            $display("timeout: no AR command for channel %0d", ch);
            errors++;
        end
        if (arvalid) begin
            expect_equal("arid", arid, ch);
            expect_equal("araddr", araddr, addr);
            expect_equal("arlen", arlen, len);
            expect_equal("arsize", arsize, rd_engine_pkg::AXSIZE_VAL);
            expect_equal("arburst", arburst, rd_engine_pkg::BURST_INCR);
            // One cycle of AR back-pressure
            if (!arready) begin
                @(posedge clk);
                #2 arready = 1'b1;
                @(negedge clk);
                assert (arvalid && arid == ch) else begin
                    $display("AR command dropped under back-pressure on channel %0d", ch);
                    errors++;
                end
            end
            @(posedge clk);
            #2 arready = ready_hold;
            @(negedge clk);
            expect_equal("alloc_req", alloc_req, 1);
            expect_equal("alloc_size", alloc_size, size);
            expect_equal("alloc_id", alloc_id, ch);
            expect_equal("sched_done", sched_done, 1 << ch);
            expect_equal("sched_beats_done", sched_beats_done[ch], size);
        end
    endtask

    // ========================================
    // R slave side with SRAM back-pressure
    // ========================================
    task automatic return_burst(input int ch, input int len, input logic [1:0] resp);
        int sent;
        int cyc;
        logic taken;
        logic [31:0] sent_q [$];
        sent = 0;
        cyc = 0;
        taken = 1'b0;
        while (sent <= len && cyc < 1000) begin
            @(posedge clk);
            #2;
            if (!rvalid || taken) begin
                lcg_state = lcg_next(lcg_state);
                rvalid = 1'b1;
                rid = 4'(ch);
                rdata = lcg_state;
                rresp = rd_engine_pkg::resp_e'(resp);
                rlast = (sent == len);
                sent_q.push_back(lcg_state);
            end
            taken = 1'b0;
            // SRAM stalls first, then drops ready every third cycle
            sram_ready = (cyc >= 4) && (cyc % 3 != 2);
            @(negedge clk);
            expect_equal("sram_valid", sram_valid, rvalid);
            expect_equal("sram_id", sram_id, rid);
            expect_equal("sram_data", sram_data, rdata);
            expect_equal("rready", rready, sram_ready);
            if (sram_valid && sram_ready) begin
                expect_equal("sram_data", sram_data, sent_q.pop_front());
                sent++;
                taken = 1'b1;
            end
            cyc++;
        end
        assert (sent == len + 1) else begin
            $display("timeout: %0d of %0d beats reached SRAM on channel %0d", sent, len + 1, ch);
            errors++;
        end
        @(posedge clk);
        #2;
        rvalid = 1'b0;
        rlast = 1'b0;
        sram_ready = 1'b1;
    endtask

    // ========================================
    // Round robin, run straight after reset
    // ========================================
    task automatic round_robin();
        int order [8] = '{0, 1, 2, 3, 1, 3, 1, 3};
        int start;
        start = errors;
        @(posedge clk);
        #2;
        cfg_xfer_beats = 8'h03;
        for (int c = 0; c < 4; c++) begin
            sched_addr[c] = 32'h0001_0000 + c * 32'h100;
            sched_beats[c] = 16'd4;
            space_free[c] = 8'hff;
        end
        sched_valid = 4'hf;
        arready = 1'b1;
        ready_hold = 1'b1;
        @(negedge clk);
        // All four outstanding after this, so no returns in between
        for (int k = 0; k < 4; k++) begin
            issue_check(order[k], 32'h0001_0000 + order[k] * 32'h100, 8'h03, 8'h04);
        end
        @(posedge clk);
        #2;
        arready = 1'b0;
        ready_hold = 1'b0;
        sched_valid = 4'b0000;
        for (int c = 0; c < 4; c++) begin
            return_burst(c, 3, 2'b00);
        end
        // Channels 1 and 3 ask together each time, so only the pointer decides
        for (int k = 4; k < 8; k++) begin
            @(posedge clk);
            #2 sched_valid = 4'b1010;
            // Grant registers on this edge, the loser must not follow it
            @(posedge clk);
            #2 sched_valid = 4'b0000;
            @(negedge clk);
            issue_check(order[k], 32'h0001_0000 + order[k] * 32'h100, 8'h03, 8'h04);
            return_burst(order[k], 3, 2'b00);
        end
        report_test(0, start);
    endtask

    // ========================================
    // One golden vector
    // ========================================
    task automatic run_vector(input int tnum, input int ch, input logic [31:0] addr,
                              input logic [15:0] beats, input logic [7:0] cfg,
                              input logic [7:0] space, input logic [1:0] resp,
                              input logic [7:0] exp_len, input logic [7:0] exp_alloc);
        int start;
        start = errors;
        @(posedge clk);
        #2;
        cfg_xfer_beats = cfg;
        sched_addr[ch] = addr;
        sched_beats[ch] = beats;
        space_free[ch] = space;
        sched_valid[ch] = 1'b1;
        // Short on space, so no command until space is raised to the exact need
        if (space < exp_alloc) begin
            for (int t = 0; t < 20; t++) begin
                @(negedge clk);
                assert (!arvalid) else begin
                    $display("AR command issued while space_free was short on channel %0d", ch);
                    errors++;
                end
            end
            @(posedge clk);
            #2 space_free[ch] = exp_alloc;
        end
        @(negedge clk);
        issue_check(ch, addr, exp_len, exp_alloc);
        // Still requesting, but the burst is outstanding
        for (int t = 0; t < 8; t++) begin
            @(negedge clk);
            assert (!arvalid && !alloc_req && sched_done == 4'b0) else begin
                $display("second command or extra pulse while channel %0d outstanding", ch);
                errors++;
            end
        end
        @(posedge clk);
        #2 sched_valid[ch] = 1'b0;
        return_burst(ch, exp_len, resp);
        exp_err[ch] = exp_err[ch] | (resp != 2'b00);
        @(negedge clk);
        expect_equal("sched_error", sched_error, exp_err);
        report_test(tnum, start);
    endtask

    int fd;
    int code;
    int n;
    int tnum;
    int ch;
    string line;
    logic [31:0] v_addr;
    logic [15:0] v_beats;
    logic [7:0] v_cfg;
    logic [7:0] v_space;
    logic [1:0] v_resp;
    logic [7:0] v_len;
    logic [7:0] v_alloc;

    initial begin
        rst_n = 1'b0;
        sched_valid = '0;
        sched_addr = '0;
        sched_beats = '0;
        cfg_xfer_beats = '0;
        space_free = '0;
        sram_ready = 1'b1;
        arready = 1'b0;
        rvalid = 1'b0;
        rid = '0;
        rdata = '0;
        rresp = rd_engine_pkg::RESP_OKAY;
        rlast = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;

        round_robin();

        fd = $fopen("verif/rd_engine_golden.txt", "r");
        assert (fd != 0) else begin
            $display("golden vector file could not be opened");
            errors++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Skip column notes and blank lines
                if (code > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %h %h %h %h %h %h %h", tnum, ch, v_addr,
                                v_beats, v_cfg, v_space, v_resp, v_len, v_alloc);
                    if (n == 9) begin
                        run_vector(tnum, ch, v_addr, v_beats, v_cfg, v_space, v_resp,
                                   v_len, v_alloc);
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && tests > 1) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rd_engine.f
src/rd_engine_pkg.sv
src/rd_channel_gate.sv
src/rr_arbiter.sv
src/ar_issue.sv
src/r_response.sv
src/rd_engine_top.sv
verif/rd_engine_tb.sv

//--- verif/rd_engine_golden.txt
# test ch addr beats cfg_xfer_beats space_free resp exp_arlen exp_alloc
# test and ch in decimal, the rest in hex; resp 0 is OKAY, 2 is SLVERR
1  0 00001000 0004 07 ff 0 03 04
2  1 00002000 0010 07 ff 0 07 08
3  2 00003000 0008 07 08 0 07 08
4  3 00004000 0020 0f 0c 0 0f 10
5  0 00005000 0001 07 ff 0 00 01
6  1 00006000 0009 07 ff 2 07 08
7  1 00007000 0003 07 ff 0 02 03
8  2 00008000 0040 1f 10 0 1f 20
9  3 00009000 0005 03 ff 0 03 04
10 0 0000a000 0100 fe ff 0 fe ff
11 2 0000b000 0002 07 01 0 01 02
12 1 0000c000 0011 07 ff 0 07 08
13 3 0000d000 0007 07 ff 0 06 07
